/* filelist.f */
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_branch_unit.sv
verilog/ex_div_ctrl.sv
verilog/ex_div_counter.sv
verilog/ex_div_datapath.sv
verilog/ex_stage.sv
tb/tb_clk_gen.sv
tb/ex_stage_assertions.sv
tb/ex_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module ex_stage_tb \
    -o ex_stage_sim > compile.log 2>&1 || { echo "compile failed, see compile.log"; exit 1; }

./obj_dir/ex_stage_sim > sim.log 2>&1

grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASSED" sim.log && { echo "simulation passed"; exit 0; } || {
    echo "simulation ended without a result, see sim.log"
    exit 1
}

/* tb/ex_stage_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage_assertions (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            kill_i,
    input  logic            hazard_i,
    input  logic            stall_i,
    input  logic            is_div_i,
    input  logic            div_done_i,
    input  logic            cap_en_i,
    input  ex_pkg::ex_res_t res_i
);

    localparam logic [7:0] DIV_CYCLES = 8'(ex_pkg::DIV_STEPS) + 8'd2;

    logic [7:0] high_cnt;

    // Rising edges seen with stall_o high
    always @(posedge clk_i) begin
        if (!rst_n_i || !stall_i) begin
            high_cnt <= '0;
        end else begin
            high_cnt <= high_cnt + 8'd1;
        end
    end

    stall_only_for_div: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(stall_i) |-> is_div_i)
        else $error("stall_o rose without a divide opcode");

    stall_not_too_long: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |-> high_cnt < DIV_CYCLES)
        else $error("stall_o high longer than the divider duration");

    stall_exact_length: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(stall_i) |-> high_cnt == DIV_CYCLES)
        else $error("stall_o fell before the divider duration");

    res_held_on_hazard: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        hazard_i && !div_done_i |=> $stable(res_i))
        else $error("res_o changed while hazard_i was high");

    kill_clears_enables: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        kill_i && cap_en_i |=> !res_i.rf_we && !res_i.tkbr)
        else $error("killed operation left rf_we or tkbr set");

endmodule : ex_stage_assertions

bind ex_stage ex_stage_assertions assertions_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .kill_i     (kill_i),
    .hazard_i   (hazard_i),
    .stall_i    (stall_o),
    .is_div_i   (is_div),
    .div_done_i (div_done),
    .cap_en_i   (cap_en),
    .res_i      (res_o)
);

`default_nettype wire

/* tb/ex_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb;

    localparam int NUM_ENTRIES = 36;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 40 + 20;
    localparam int HAZARD_CYCLES = 3;

    logic            clk;
    logic            rst_n;
    logic            kill;
    logic            hazard;
    ex_pkg::ex_req_t req;
    ex_pkg::ex_res_t res;
    logic            stall;

    ex_pkg::ex_req_t req_tab [NUM_ENTRIES];
    logic            kill_tab [NUM_ENTRIES];
    logic            hazard_tab [NUM_ENTRIES];
    ex_pkg::ex_res_t exp_tab [NUM_ENTRIES];

    integer seed;
    int     cycles = 0;

    tb_clk_gen clk_gen_inst (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    ex_stage ex_stage_inst (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .kill_i   (kill),
        .hazard_i (hazard),
        .req_i    (req),
        .res_o    (res),
        .stall_o  (stall)
    );

    task automatic fail_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            fail_run();
        end
    end

    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("error at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
            fail_run();
        end
    endtask

    task automatic compare_res(input ex_pkg::ex_res_t exp_r, input ex_pkg::ex_res_t act_r);
        check_field("res_o.alu_res", exp_r.alu_res, act_r.alu_res);
        check_field("res_o.rf_we", 32'(exp_r.rf_we), 32'(act_r.rf_we));
        check_field("res_o.rf_waddr", 32'(exp_r.rf_waddr), 32'(act_r.rf_waddr));
        check_field("res_o.csr_access", 32'(exp_r.csr_access), 32'(act_r.csr_access));
        check_field("res_o.csr_waddr", 32'(exp_r.csr_waddr), 32'(act_r.csr_waddr));
        check_field("res_o.csr_data", exp_r.csr_data, act_r.csr_data);
        check_field("res_o.branch_completed", 32'(exp_r.branch_completed),
                    32'(act_r.branch_completed));
        check_field("res_o.tkbr", 32'(exp_r.tkbr), 32'(act_r.tkbr));
        check_field("res_o.new_pc", exp_r.new_pc, act_r.new_pc);
        check_field("res_o.instr_id", 32'(exp_r.instr_id), 32'(act_r.instr_id));
    endtask

    task automatic compare_bit(input string name, input logic exp_b, input logic act_b);
        if (exp_b !== act_b) begin
            $display("error at %0t: %s expected %b got %b", $time, name, exp_b, act_b);
            fail_run();
        end
    endtask

    task automatic compare_count(input string name, input int exp_c, input int act_c);
        if (exp_c != act_c) begin
            $display("error at %0t: %s expected %0d got %0d", $time, name, exp_c, act_c);
            fail_run();
        end
    endtask

    // Fills one table row; pass-through fields follow from the index
    task automatic add_entry(input int idx, input ex_pkg::alu_opcode_e op,
                             input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] bra, input logic [31:0] brb,
                             input logic k, input logic h,
                             input logic [31:0] exp_word, input logic [31:0] exp_pc,
                             input logic exp_tk);
        logic branch;
        branch = (op >= ex_pkg::ALU_BEQ) && (op <= ex_pkg::ALU_JALR);
        req_tab[idx].opcode     = op;
        req_tab[idx].alu_src_a  = a;
        req_tab[idx].alu_src_b  = b;
        req_tab[idx].br_src_a   = bra;
        req_tab[idx].br_src_b   = brb;
        req_tab[idx].rf_we      = 1'b1;
        req_tab[idx].rf_waddr   = 5'(idx + 1);
        req_tab[idx].csr_access = idx[0];
        req_tab[idx].csr_waddr  = 12'h300 + 12'(idx);
        req_tab[idx].instr_id   = 4'(idx);
        kill_tab[idx]   = k;
        hazard_tab[idx] = h;
        exp_tab[idx].alu_res          = exp_word;
        exp_tab[idx].rf_we            = !k;
        exp_tab[idx].rf_waddr         = 5'(idx + 1);
        exp_tab[idx].csr_access       = idx[0] && !k;
        exp_tab[idx].csr_waddr        = 12'h300 + 12'(idx);
        exp_tab[idx].csr_data         = a;
        exp_tab[idx].branch_completed = branch && !k;
        exp_tab[idx].tkbr             = exp_tk && !k;
        exp_tab[idx].new_pc           = exp_pc;
        exp_tab[idx].instr_id         = 4'(idx);
    endtask

    task automatic build_table();
        logic [31:0] ra;
        logic [31:0] rb;
        add_entry(0, ex_pkg::ALU_ADD, 32'h5, 32'h7, 0, 0, 0, 0, 32'hc, 32'hc, 0);
        // Divide by zero gives the dividend back as remainder
        add_entry(1, ex_pkg::ALU_REMU, 32'h4d2, 32'h0, 0, 0, 0, 0, 32'h4d2, 32'h4d2, 0);
        add_entry(2, ex_pkg::ALU_SUB, 32'h5, 32'h7, 0, 0, 0, 0, 32'hfffffffe, 32'hfffffffe, 0);
        add_entry(3, ex_pkg::ALU_AND, 32'hf0f0, 32'hff00, 0, 0, 0, 0, 32'hf000, 32'hf000, 0);
        add_entry(4, ex_pkg::ALU_OR, 32'hf0f0, 32'hff00, 0, 0, 0, 0, 32'hfff0, 32'hfff0, 0);
        add_entry(5, ex_pkg::ALU_XOR, 32'hf0f0, 32'hff00, 0, 0, 0, 0, 32'h0ff0, 32'h0ff0, 0);
        // Shift amount 33 keeps only its low five bits
        add_entry(6, ex_pkg::ALU_SLL, 32'h1, 32'h21, 0, 0, 0, 0, 32'h2, 32'h2, 0);
        add_entry(7, ex_pkg::ALU_SRL, 32'h80000000, 32'h4, 0, 0, 0, 0,
                  32'h08000000, 32'h08000000, 0);
        add_entry(8, ex_pkg::ALU_SRA, 32'h80000000, 32'h4, 0, 0, 0, 0,
                  32'hf8000000, 32'hf8000000, 0);
        add_entry(9, ex_pkg::ALU_SLT, 32'hfffffff0, 32'h1, 0, 0, 0, 0, 32'h1, 32'h1, 0);
        add_entry(10, ex_pkg::ALU_SLTU, 32'hfffffff0, 32'h1, 0, 0, 0, 0, 32'h0, 32'h0, 0);
        add_entry(11, ex_pkg::ALU_BEQ, 32'h64, 32'h8, 32'h3, 32'h3, 0, 0, 32'h6c, 32'h6c, 1);
        add_entry(12, ex_pkg::ALU_BNE, 32'h64, 32'h8, 32'h3, 32'h3, 0, 0, 32'h6c, 32'h6c, 0);
        add_entry(13, ex_pkg::ALU_BLT, 32'h64, 32'h8, 32'hffffffff, 32'h1, 0, 0,
                  32'h6c, 32'h6c, 1);
        add_entry(14, ex_pkg::ALU_BGE, 32'h64, 32'h8, 32'hffffffff, 32'h1, 0, 0,
                  32'h6c, 32'h6c, 0);
        add_entry(15, ex_pkg::ALU_BLTU, 32'h64, 32'h8, 32'hffffffff, 32'h1, 0, 0,
                  32'h6c, 32'h6c, 0);
        add_entry(16, ex_pkg::ALU_BGEU, 32'h64, 32'h8, 32'hffffffff, 32'h1, 0, 0,
                  32'h6c, 32'h6c, 1);
        // Jumps return the link value from br_src_a
        add_entry(17, ex_pkg::ALU_JAL, 32'h200, 32'h10, 32'h204, 32'h0, 0, 0,
                  32'h204, 32'h210, 1);
        add_entry(18, ex_pkg::ALU_JALR, 32'h300, 32'hfffffffc, 32'h104, 32'h0, 0, 0,
                  32'h104, 32'h2fc, 1);
        add_entry(19, ex_pkg::ALU_DIVU, 32'h64, 32'h7, 0, 0, 0, 0, 32'he, 32'h6b, 0);
        ra = $random(seed);
        rb = $random(seed);
        add_entry(20, ex_pkg::ALU_ADD, ra, rb, 0, 0, 0, 1, ra + rb, ra + rb, 0);
        add_entry(21, ex_pkg::ALU_DIVU, 32'h4d2, 32'h0, 0, 0, 0, 0,
                  32'hffffffff, 32'h4d2, 0);
        ra = $random(seed);
        rb = $random(seed);
        add_entry(22, ex_pkg::ALU_BNE, ra, rb, ra, rb, 1, 0, ra + rb, ra + rb, ra != rb);
        ra = $random(seed);
        rb = $random(seed) | 1;
        add_entry(23, ex_pkg::ALU_REMU, ra, rb, 0, 0, 0, 0, ra % rb, ra + rb, 0);
        // Remaining operand orders for each branch condition
        add_entry(24, ex_pkg::ALU_BEQ, 32'h64, 32'h8, 32'h1, 32'h2, 0, 0, 32'h6c, 32'h6c, 0);
        add_entry(25, ex_pkg::ALU_BEQ, 32'h64, 32'h8, 32'h2, 32'h1, 0, 0, 32'h6c, 32'h6c, 0);
        add_entry(26, ex_pkg::ALU_BNE, 32'h64, 32'h8, 32'h1, 32'h2, 0, 0, 32'h6c, 32'h6c, 1);
        add_entry(27, ex_pkg::ALU_BNE, 32'h64, 32'h8, 32'h2, 32'h1, 0, 0, 32'h6c, 32'h6c, 1);
        add_entry(28, ex_pkg::ALU_BLT, 32'h64, 32'h8, 32'h3, 32'h3, 0, 0, 32'h6c, 32'h6c, 0);
        add_entry(29, ex_pkg::ALU_BLT, 32'h64, 32'h8, 32'h1, 32'hffffffff, 0, 0,
                  32'h6c, 32'h6c, 0);
        add_entry(30, ex_pkg::ALU_BGE, 32'h64, 32'h8, 32'h3, 32'h3, 0, 0, 32'h6c, 32'h6c, 1);
        add_entry(31, ex_pkg::ALU_BGE, 32'h64, 32'h8, 32'h1, 32'hffffffff, 0, 0,
                  32'h6c, 32'h6c, 1);
        add_entry(32, ex_pkg::ALU_BLTU, 32'h64, 32'h8, 32'h3, 32'h3, 0, 0, 32'h6c, 32'h6c, 0);
        add_entry(33, ex_pkg::ALU_BLTU, 32'h64, 32'h8, 32'h1, 32'hffffffff, 0, 0,
                  32'h6c, 32'h6c, 1);
        add_entry(34, ex_pkg::ALU_BGEU, 32'h64, 32'h8, 32'h3, 32'h3, 0, 0, 32'h6c, 32'h6c, 1);
        add_entry(35, ex_pkg::ALU_BGEU, 32'h64, 32'h8, 32'h1, 32'hffffffff, 0, 0,
                  32'h6c, 32'h6c, 0);
    endtask

    task automatic apply_entry(input int idx);
        int              stall_cycles;
        ex_pkg::ex_res_t held;
        logic            is_div;
        held   = res;
        is_div = (req_tab[idx].opcode == ex_pkg::ALU_DIVU)
              || (req_tab[idx].opcode == ex_pkg::ALU_REMU);
        req    = req_tab[idx];
        kill   = kill_tab[idx];
        hazard = hazard_tab[idx];
        if (hazard_tab[idx]) begin
            repeat (HAZARD_CYCLES) begin
                @(negedge clk);
                compare_res(held, res);
            end
            hazard = 1'b0;
        end
        stall_cycles = 0;
        @(negedge clk);
        while (stall) begin
            // Output must not move while the divider runs
            compare_res(held, res);
            stall_cycles = stall_cycles + 1;
            @(negedge clk);
        end
        compare_res(exp_tab[idx], res);
        if (is_div) begin
            // Accept cycle plus the cycles seen high afterwards
            compare_count("stall_o high cycles", int'(ex_pkg::DIV_STEPS) + 2,
                          stall_cycles + 1);
        end else begin
            compare_count("stall_o high cycles", 0, stall_cycles);
        end
    endtask

    initial begin
        seed   = 78;
        req    = '0;
        kill   = 1'b0;
        hazard = 1'b0;
        build_table();
        @(posedge rst_n);
        compare_res('0, res);
        compare_bit("stall_o", 1'b0, stall);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            apply_entry(i);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule : ex_stage_tb

`default_nettype wire

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int unsigned HALF_PERIOD = 10;

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

    // Reset held low over two rising edges, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule : tb_clk_gen

`default_nettype wire

/* verilog/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  ex_pkg::alu_opcode_e             opcode_i,
    input  logic [ex_pkg::WORD_SIZE-1:0]    src_a_i,
    input  logic [ex_pkg::WORD_SIZE-1:0]    src_b_i,
    output logic [ex_pkg::WORD_SIZE-1:0]    res_o
);

    logic [ex_pkg::WORD_SIZE-1:0] sum;
    logic [4:0]                   shamt;

    // Sum doubles as the target address for branches and jumps
    assign sum   = src_a_i + src_b_i;
    assign shamt = src_b_i[4:0];

    always_comb begin
        res_o = '0;
        case (opcode_i)
            ex_pkg::ALU_ADD: begin
                res_o = sum;
            end
            ex_pkg::ALU_SUB: begin
                res_o = src_a_i - src_b_i;
            end
            ex_pkg::ALU_AND: begin
                res_o = src_a_i & src_b_i;
            end
            ex_pkg::ALU_OR: begin
                res_o = src_a_i | src_b_i;
            end
            ex_pkg::ALU_XOR: begin
                res_o = src_a_i ^ src_b_i;
            end
            ex_pkg::ALU_SLL: begin
                res_o = src_a_i << shamt;
            end
            ex_pkg::ALU_SRL: begin
                res_o = src_a_i >> shamt;
            end
            ex_pkg::ALU_SRA: begin
                res_o = $signed(src_a_i) >>> shamt;
            end
            ex_pkg::ALU_SLT: begin
                res_o[0] = $signed(src_a_i) < $signed(src_b_i);
            end
            ex_pkg::ALU_SLTU: begin
                res_o[0] = src_a_i < src_b_i;
            end
            ex_pkg::ALU_BEQ, ex_pkg::ALU_BNE, ex_pkg::ALU_BLT, ex_pkg::ALU_BGE,
            ex_pkg::ALU_BLTU, ex_pkg::ALU_BGEU, ex_pkg::ALU_JAL, ex_pkg::ALU_JALR: begin
                res_o = sum;
            end
            default: begin
                // Divide opcodes take their word from the divider
                res_o = sum;
            end
        endcase
    end

endmodule : ex_alu

`default_nettype wire

/* verilog/ex_branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit (
    input  ex_pkg::alu_opcode_e             opcode_i,
    input  logic [ex_pkg::WORD_SIZE-1:0]    src_a_i,
    input  logic [ex_pkg::WORD_SIZE-1:0]    src_b_i,
    output logic                            tkbr_o,
    output logic                            completed_o
);

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = src_a_i == src_b_i;
    assign lt  = $signed(src_a_i) < $signed(src_b_i);
    assign ltu = src_a_i < src_b_i;

    always_comb begin
        tkbr_o      = 1'b0;
        completed_o = 1'b1;
        case (opcode_i)
            ex_pkg::ALU_BEQ:  tkbr_o = eq;
            ex_pkg::ALU_BNE:  tkbr_o = !eq;
            ex_pkg::ALU_BLT:  tkbr_o = lt;
            ex_pkg::ALU_BGE:  tkbr_o = !lt;
            ex_pkg::ALU_BLTU: tkbr_o = ltu;
            ex_pkg::ALU_BGEU: tkbr_o = !ltu;
            // Unconditional
            ex_pkg::ALU_JAL, ex_pkg::ALU_JALR: begin
                tkbr_o = 1'b1;
            end
            default: begin
                completed_o = 1'b0;
            end
        endcase
    end

endmodule : ex_branch_unit

`default_nettype wire

/* verilog/ex_div_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_div_counter (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic load_i,
    input  logic step_i,
    output logic last_o
);

    logic [ex_pkg::DIV_CNT_SIZE-1:0] cnt_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= ex_pkg::DIV_STEPS;
        end else if (step_i) begin
            cnt_q <= cnt_q - ex_pkg::DIV_CNT_SIZE'(1);
        end
    end

    // One iteration left
    assign last_o = cnt_q == ex_pkg::DIV_CNT_SIZE'(1);

endmodule : ex_div_counter

`default_nettype wire

/* verilog/ex_div_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_div_ctrl (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic start_i,
    input  logic last_i,
    output logic load_o,
    output logic step_o,
    output logic busy_o,
    output logic done_o
);

    ex_pkg::div_state_e state_q;
    ex_pkg::div_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ex_pkg::DIV_IDLE: begin
                if (start_i) begin
                    state_d = ex_pkg::DIV_RUN;
                end
            end
            ex_pkg::DIV_RUN: begin
                if (last_i) begin
                    state_d = ex_pkg::DIV_DONE;
                end
            end
            ex_pkg::DIV_DONE: begin
                state_d = ex_pkg::DIV_IDLE;
            end
            default: begin
                state_d = ex_pkg::DIV_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ex_pkg::DIV_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Start is only honoured from idle
    assign load_o = (state_q == ex_pkg::DIV_IDLE) && start_i;
    assign step_o = state_q == ex_pkg::DIV_RUN;
    assign done_o = state_q == ex_pkg::DIV_DONE;

    // Busy already in the accept cycle so the stage stalls at once
    assign busy_o = load_o || step_o || done_o;

endmodule : ex_div_ctrl

`default_nettype wire

/* verilog/ex_div_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_div_datapath (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            load_i,
    input  logic                            step_i,
    input  logic [ex_pkg::WORD_SIZE-1:0]    dividend_i,
    input  logic [ex_pkg::WORD_SIZE-1:0]    divisor_i,
    output logic [ex_pkg::WORD_SIZE-1:0]    quotient_o,
    output logic [ex_pkg::WORD_SIZE-1:0]    remainder_o
);

    localparam int unsigned W = ex_pkg::WORD_SIZE;

    // Quotient register starts out holding the dividend and
    // shifts it out at the top while quotient bits enter at the bottom
    logic [W-1:0] rem_q;
    logic [W-1:0] quo_q;
    logic [W-1:0] div_q;

    logic [W:0]   shifted;
    logic [W:0]   diff;
    logic         fits;

    assign shifted = {rem_q, quo_q[W-1]};
    assign diff    = shifted - {1'b0, div_q};
    // No borrow means the divisor fits into the partial remainder
    assign fits    = !diff[W];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rem_q <= '0;
            quo_q <= '0;
            div_q <= '0;
        end else if (load_i) begin
            rem_q <= '0;
            quo_q <= dividend_i;
            div_q <= divisor_i;
        end else if (step_i) begin
            if (fits) begin
                rem_q <= diff[W-1:0];
            end else begin
                rem_q <= shifted[W-1:0];
            end
            quo_q <= {quo_q[W-2:0], fits};
        end
    end

    // Zero divisor always fits, giving all ones and the dividend back
    assign quotient_o  = quo_q;
    assign remainder_o = rem_q;

endmodule : ex_div_datapath

`default_nettype wire

/* verilog/ex_pkg.sv */
`default_nettype none

package ex_pkg;

    // Datapath and field widths
    localparam int unsigned WORD_SIZE = 32;
    localparam int unsigned REG_SIZE  = 5;
    localparam int unsigned CSR_SIZE  = 12;
    localparam int unsigned ID_SIZE   = 4;

    // Divider sizing, one iteration per quotient bit
    localparam int unsigned DIV_CNT_SIZE = 6;
    localparam logic [DIV_CNT_SIZE-1:0] DIV_STEPS = DIV_CNT_SIZE'(WORD_SIZE);

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU,
        ALU_JAL,
        ALU_JALR,
        ALU_DIVU,
        ALU_REMU
    } alu_opcode_e;

    // Decoded operation from the decode stage
    typedef struct packed {
        alu_opcode_e           opcode;
        logic [WORD_SIZE-1:0]  alu_src_a;
        logic [WORD_SIZE-1:0]  alu_src_b;
        logic [WORD_SIZE-1:0]  br_src_a;
        logic [WORD_SIZE-1:0]  br_src_b;
        logic                  rf_we;
        logic [REG_SIZE-1:0]   rf_waddr;
        logic                  csr_access;
        logic [CSR_SIZE-1:0]   csr_waddr;
        logic [ID_SIZE-1:0]    instr_id;
    } ex_req_t;

    // Registered result towards writeback
    typedef struct packed {
        logic [WORD_SIZE-1:0]  alu_res;
        logic                  rf_we;
        logic [REG_SIZE-1:0]   rf_waddr;
        logic                  csr_access;
        logic [CSR_SIZE-1:0]   csr_waddr;
        logic [WORD_SIZE-1:0]  csr_data;
        logic                  branch_completed;
        logic                  tkbr;
        logic [WORD_SIZE-1:0]  new_pc;
        logic [ID_SIZE-1:0]    instr_id;
    } ex_res_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

endpackage : ex_pkg

`default_nettype wire

/* verilog/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            kill_i,
    input  logic            hazard_i,
    input  ex_pkg::ex_req_t req_i,
    output ex_pkg::ex_res_t res_o,
    output logic            stall_o
);

    logic [ex_pkg::WORD_SIZE-1:0] alu_word;
    logic [ex_pkg::WORD_SIZE-1:0] quotient;
    logic [ex_pkg::WORD_SIZE-1:0] remainder;
    logic [ex_pkg::WORD_SIZE-1:0] res_word;
    logic                         tkbr;
    logic                         br_completed;
    logic                         is_div;
    logic                         is_jump;
    logic                         div_start;
    logic                         div_load;
    logic                         div_step;
    logic                         div_busy;
    logic                         div_done;
    logic                         div_last;
    logic                         div_ack_q;
    logic                         cap_en;
    ex_pkg::ex_res_t              res_d;

    ex_alu alu_inst (
        .opcode_i (req_i.opcode),
        .src_a_i  (req_i.alu_src_a),
        .src_b_i  (req_i.alu_src_b),
        .res_o    (alu_word)
    );

    ex_branch_unit branch_inst (
        .opcode_i    (req_i.opcode),
        .src_a_i     (req_i.br_src_a),
        .src_b_i     (req_i.br_src_b),
        .tkbr_o      (tkbr),
        .completed_o (br_completed)
    );

    assign is_div  = (req_i.opcode == ex_pkg::ALU_DIVU) || (req_i.opcode == ex_pkg::ALU_REMU);
    assign is_jump = (req_i.opcode == ex_pkg::ALU_JAL) || (req_i.opcode == ex_pkg::ALU_JALR);

    // A finished divide stays on req_i until upstream advances,
    // so it must not start a second time
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            div_ack_q <= 1'b0;
        end else if (div_done) begin
            div_ack_q <= 1'b1;
        end else if (!hazard_i) begin
            div_ack_q <= 1'b0;
        end
    end

    // Control is idle when neither running nor finishing
    assign div_start = is_div && !hazard_i && !div_step && !div_done && !div_ack_q;

    ex_div_ctrl div_ctrl_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .start_i (div_start),
        .last_i  (div_last),
        .load_o  (div_load),
        .step_o  (div_step),
        .busy_o  (div_busy),
        .done_o  (div_done)
    );

    ex_div_counter div_counter_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .load_i  (div_load),
        .step_i  (div_step),
        .last_o  (div_last)
    );

    ex_div_datapath div_datapath_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .load_i      (div_load),
        .step_i      (div_step),
        .dividend_i  (req_i.alu_src_a),
        .divisor_i   (req_i.alu_src_b),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    always_comb begin
        if (is_jump) begin
            res_word = req_i.br_src_a;
        end else if (req_i.opcode == ex_pkg::ALU_DIVU) begin
            res_word = quotient;
        end else if (req_i.opcode == ex_pkg::ALU_REMU) begin
            res_word = remainder;
        end else begin
            res_word = alu_word;
        end
    end

    // Kill masks only the fields that change architectural state
    always_comb begin
        res_d.alu_res          = res_word;
        res_d.rf_we            = req_i.rf_we && !kill_i;
        res_d.rf_waddr         = req_i.rf_waddr;
        res_d.csr_access       = req_i.csr_access && !kill_i;
        res_d.csr_waddr        = req_i.csr_waddr;
        res_d.csr_data         = req_i.alu_src_a;
        res_d.branch_completed = br_completed && !kill_i;
        res_d.tkbr             = tkbr && !kill_i;
        res_d.new_pc           = alu_word;
        res_d.instr_id         = req_i.instr_id;
    end

    // Divide result lands as the control leaves DIV_DONE
    assign cap_en = div_done || (!hazard_i && !div_busy);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            res_o <= '0;
        end else if (cap_en) begin
            res_o <= res_d;
        end
    end

    assign stall_o = div_busy;

endmodule : ex_stage

`default_nettype wire
